// File: tiaPkg.sv
// ######################################
// TIA object slice shared definitions
// Register map, widths and NUSIZ layout
// ######################################
package tiaPkg;

  // Pixel numbers and object positions
  localparam int PixW = 8;

  // Pixels after the position strobe that one object can cover
  localparam int ObjWindow = 72;

  localparam int AddrW = 3;

  // Register map
  localparam logic [AddrW-1:0] AddrNusiz  = 3'd0;
  localparam logic [AddrW-1:0] AddrGrp    = 3'd1;
  localparam logic [AddrW-1:0] AddrColup  = 3'd2;
  localparam logic [AddrW-1:0] AddrColubk = 3'd3;
  localparam logic [AddrW-1:0] AddrResp   = 3'd4;
  localparam logic [AddrW-1:0] AddrResm   = 3'd5;
  // Bit 0 vertical delay, bit 1 missile enable
  localparam logic [AddrW-1:0] AddrCtrl   = 3'd6;
  localparam logic [AddrW-1:0] AddrCxclr  = 3'd7;

  // Decoded NUSIZ byte
  typedef struct packed {
    logic [1:0] missileSize;
    logic [2:0] unused;
    logic [2:0] objSize;
  } nusizFieldsS;

  // Stored raw by the register file, read as fields by the renderer
  typedef union packed {
    logic [7:0]  raw;
    nusizFieldsS fields;
  } nusizU;

endpackage

// File: scanCounter.sv
// ######################################
// Scanline counter
// Pixel number across a line, line start flag
// ######################################
`timescale 1ns/10ps

module scanCounter #(
  parameter int LineWidth = 160
) (
  input  logic                    clk,
  input  logic                    rstN,
  output logic [tiaPkg::PixW-1:0] pixelNum,
  output logic                    lineStart
);

  localparam logic [tiaPkg::PixW-1:0] LastPixel = tiaPkg::PixW'(LineWidth - 1);

  logic [tiaPkg::PixW-1:0] pixelNext;
  logic                    atLineEnd;

  assign atLineEnd = (pixelNum == LastPixel);

  // Wrap back to pixel 0 after the last visible pixel
  assign pixelNext = atLineEnd ? '0 : pixelNum + 1'b1;

  // Flag is registered alongside the counter so it marks pixel 0 exactly
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pixelNum  <= '0;
      lineStart <= 1'b1;
    end else begin
      pixelNum  <= pixelNext;
      lineStart <= atLineEnd;
    end
  end

endmodule

// File: objRegs.sv
// ######################################
// Object register file
// Byte writes, position strobes, graphics delay
// ######################################
`timescale 1ns/10ps

module objRegs (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     wrEn,
  input  logic [tiaPkg::AddrW-1:0] wrAddr,
  input  logic [7:0]               wrData,
  input  logic [tiaPkg::PixW-1:0]  pixelNum,
  input  logic                     lineStart,
  output tiaPkg::nusizU            nusiz,
  output logic [7:0]               objGrp,
  output logic [tiaPkg::PixW-1:0]  playerPos,
  output logic [tiaPkg::PixW-1:0]  missilePos,
  output logic [7:0]               colup,
  output logic [7:0]               colubk,
  output logic                     missileEnable,
  output logic                     clearCollision
);

  logic [7:0] grpNew;
  logic [7:0] grpOld;
  logic       vDelay;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      nusiz          <= '0;
      grpNew         <= '0;
      grpOld         <= '0;
      playerPos      <= '0;
      missilePos     <= '0;
      colup          <= '0;
      colubk         <= '0;
      vDelay         <= 1'b0;
      missileEnable  <= 1'b0;
      clearCollision <= 1'b0;
    end else begin
      clearCollision <= 1'b0;

      // Old copy follows the new one once per line
      if (lineStart) begin
        grpOld <= grpNew;
      end

      if (wrEn) begin
        case (wrAddr)
          tiaPkg::AddrNusiz:  nusiz.raw <= wrData;
          tiaPkg::AddrGrp:    grpNew <= wrData;
          tiaPkg::AddrColup:  colup <= wrData;
          tiaPkg::AddrColubk: colubk <= wrData;
          // Position strobes latch the beam position, data is ignored
          tiaPkg::AddrResp:   playerPos <= pixelNum;
          tiaPkg::AddrResm:   missilePos <= pixelNum;
          tiaPkg::AddrCtrl: begin
            vDelay        <= wrData[0];
            missileEnable <= wrData[1];
          end
          tiaPkg::AddrCxclr:  clearCollision <= 1'b1;
        endcase
      end
    end
  end

  // Vertical delay shows last line's graphics
  assign objGrp = vDelay ? grpOld : grpNew;

endmodule

// File: objPixelOn.sv
// ######################################
// Object pixel decision
// Window, copy slot and mask bit test
// ######################################
`timescale 1ns/10ps

module objPixelOn (
  input  logic [tiaPkg::PixW-1:0] pixelNum,
  input  logic [tiaPkg::PixW-1:0] objPos,
  input  logic [2:0]              objSize,
  input  logic [7:0]              objMask,
  output logic                    pixelOn
);

  logic [tiaPkg::PixW-1:0] objIndex;
  logic [8:0]              objByteIndex;
  logic [8:0]              slotMask;
  logic [2:0]              maskSel;
  logic                    objPosOn;
  logic                    objSizeOn;
  logic                    objMaskOn;

  // First lit pixel is one past the strobe position
  assign objIndex = pixelNum - objPos - 1'b1;

  // One hot 8-pixel slot, nine slots over the window
  assign objByteIndex = 9'b1 << objIndex[tiaPkg::PixW-1:3];

  assign objPosOn = (pixelNum > objPos) &&
                    (int'(pixelNum) <= int'(objPos) + tiaPkg::ObjWindow);

  // Slots where a copy is drawn for each size code
  always_comb begin
    case (objSize)
      3'd0: slotMask = 9'b000000001;
      3'd1: slotMask = 9'b000000101;
      3'd2: slotMask = 9'b000010001;
      3'd3: slotMask = 9'b000010101;
      3'd4: slotMask = 9'b100000001;
      3'd5: slotMask = 9'b000000011;
      3'd6: slotMask = 9'b100010001;
      default: slotMask = 9'b000001111;
    endcase
  end

  assign objSizeOn = |(objByteIndex & slotMask);

  // Double and quad width stretch each mask bit
  always_comb begin
    case (objSize)
      3'd5: maskSel = objIndex[3:1];
      3'd7: maskSel = objIndex[4:2];
      default: maskSel = objIndex[2:0];
    endcase
  end

  // Bit 0 is drawn first
  assign objMaskOn = objMask[maskSel];

  assign pixelOn = objPosOn & objSizeOn & objMaskOn;

endmodule

// File: objRender.sv
// ######################################
// Object renderer
// Player/missile color and collision latch
// ######################################
`timescale 1ns/10ps

module objRender (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [tiaPkg::PixW-1:0] pixelNum,
  input  tiaPkg::nusizU           nusiz,
  input  logic [7:0]              objGrp,
  input  logic [tiaPkg::PixW-1:0] playerPos,
  input  logic [tiaPkg::PixW-1:0] missilePos,
  input  logic                    missileEnable,
  input  logic [7:0]              colup,
  input  logic [7:0]              colubk,
  input  logic                    clearCollision,
  output logic [7:0]              colorOut,
  output logic [tiaPkg::PixW-1:0] pixelX,
  output logic                    collision
);

  logic [7:0] missileMask;
  logic       playerOn;
  logic       missileOn;

  // Missile width is 1, 2, 4 or 8 pixels
  always_comb begin
    case (nusiz.fields.missileSize)
      2'd0: missileMask = 8'h01;
      2'd1: missileMask = 8'h03;
      2'd2: missileMask = 8'h0f;
      default: missileMask = 8'hff;
    endcase
    if (!missileEnable) begin
      missileMask = 8'h00;
    end
  end

  objPixelOn playerPix (
    .pixelNum (pixelNum),
    .objPos   (playerPos),
    .objSize  (nusiz.fields.objSize),
    .objMask  (objGrp),
    .pixelOn  (playerOn)
  );

  // Single unstretched copy, width comes from the mask alone
  objPixelOn missilePix (
    .pixelNum (pixelNum),
    .objPos   (missilePos),
    .objSize  (3'd0),
    .objMask  (missileMask),
    .pixelOn  (missileOn)
  );

  always_ff @(posedge clk) begin
    if (!rstN) begin
      colorOut  <= '0;
      pixelX    <= '0;
      collision <= 1'b0;
    end else begin
      pixelX   <= pixelNum;
      colorOut <= (playerOn | missileOn) ? colup : colubk;
      // Clear wins over a hit on the same pixel
      if (clearCollision) begin
        collision <= 1'b0;
      end else if (playerOn & missileOn) begin
        collision <= 1'b1;
      end
    end
  end

endmodule

// File: tiaObjTop.sv
// ######################################
// TIA object slice top level
// ######################################
`timescale 1ns/10ps

module tiaObjTop #(
  parameter int LineWidth = 160
) (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     wrEn,
  input  logic [tiaPkg::AddrW-1:0] wrAddr,
  input  logic [7:0]               wrData,
  output logic [7:0]               colorOut,
  output logic [tiaPkg::PixW-1:0]  pixelX,
  output logic                     collision
);

  logic [tiaPkg::PixW-1:0] pixelNum;
  logic                    lineStart;
  tiaPkg::nusizU           nusiz;
  logic [7:0]              objGrp;
  logic [tiaPkg::PixW-1:0] playerPos;
  logic [tiaPkg::PixW-1:0] missilePos;
  logic                    missileEnable;
  logic [7:0]              colup;
  logic [7:0]              colubk;
  logic                    clearCollision;

  scanCounter #(
    .LineWidth (LineWidth)
  ) counter (
    .clk       (clk),
    .rstN      (rstN),
    .pixelNum  (pixelNum),
    .lineStart (lineStart)
  );

  objRegs regs (
    .clk            (clk),
    .rstN           (rstN),
    .wrEn           (wrEn),
    .wrAddr         (wrAddr),
    .wrData         (wrData),
    .pixelNum       (pixelNum),
    .lineStart      (lineStart),
    .nusiz          (nusiz),
    .objGrp         (objGrp),
    .playerPos      (playerPos),
    .missilePos     (missilePos),
    .colup          (colup),
    .colubk         (colubk),
    .missileEnable  (missileEnable),
    .clearCollision (clearCollision)
  );

  objRender render (
    .clk            (clk),
    .rstN           (rstN),
    .pixelNum       (pixelNum),
    .nusiz          (nusiz),
    .objGrp         (objGrp),
    .playerPos      (playerPos),
    .missilePos     (missilePos),
    .missileEnable  (missileEnable),
    .colup          (colup),
    .colubk         (colubk),
    .clearCollision (clearCollision),
    .colorOut       (colorOut),
    .pixelX         (pixelX),
    .collision      (collision)
  );

endmodule

// File: objPixelOn_checker.sv
// ########################################
// Renderer assertion checker
// Output, collision and player window rules
// ########################################
`timescale 1ns/10ps

module objPixelOnChecker (
  input logic                    clk,
  input logic                    rstN,
  input logic [tiaPkg::PixW-1:0] pixelNum,
  input logic [tiaPkg::PixW-1:0] playerPos,
  input logic                    playerOn,
  input logic [7:0]              colorOut,
  input logic                    collision,
  input logic                    clearCollision
);

  int assertFails = 0;

  // Color byte always defined once out of reset
  colorKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(colorOut))
    else begin
      $error("colorOut is unknown");
      assertFails = assertFails + 1;
    end

  // Latch only drops the cycle after a clear pulse
  collisionHeld: assert property (@(posedge clk) disable iff (!rstN)
    $fell(collision) |-> $past(clearCollision))
    else begin
      $error("collision fell without a clear");
      assertFails = assertFails + 1;
    end

  // Player lit only between position + 1 and position + window
  playerInWindow: assert property (@(posedge clk) disable iff (!rstN)
    playerOn |-> (pixelNum > playerPos) &&
                 (int'(pixelNum) <= int'(playerPos) + tiaPkg::ObjWindow))
    else begin
      $error("player lit outside its window");
      assertFails = assertFails + 1;
    end

endmodule

bind objRender objPixelOnChecker renderChecker (
  .clk            (clk),
  .rstN           (rstN),
  .pixelNum       (pixelNum),
  .playerPos      (playerPos),
  .playerOn       (playerOn),
  .colorOut       (colorOut),
  .collision      (collision),
  .clearCollision (clearCollision)
);

// File: tiaObjClock.sv
// ########################################
// Testbench clock and reset generator
// ########################################
`timescale 1ns/10ps

module tiaObjClock #(
  parameter int ResetCycles = 16
) (
  output logic clk,
  output logic rstN
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

// File: tiaObjTb.sv
// ########################################
// TIA object slice testbench
// Register writes, pixel model, per-cycle compare
// ########################################
`timescale 1ns/10ps

module tiaObjTb;

  localparam int LineWidth = 160;
  localparam int ResetCycles = 16;
  localparam int TimeoutCycles = 40 * LineWidth + ResetCycles;

  logic                     clk;
  logic                     rstN;
  logic                     wrEn;
  logic [tiaPkg::AddrW-1:0] wrAddr;
  logic [7:0]               wrData;
  logic [7:0]               colorOut;
  logic [tiaPkg::PixW-1:0]  pixelX;
  logic                     collision;

  // Model copies of the written registers
  logic [7:0] mPix;
  logic       mLineStart;
  logic [7:0] mNusiz;
  logic [7:0] mGrpNew;
  logic [7:0] mGrpOld;
  logic       mVdelay;
  logic       mMisEn;
  logic [7:0] mPlayerPos;
  logic [7:0] mMisPos;
  logic [7:0] mColup;
  logic [7:0] mColubk;
  logic       mClear;
  logic [7:0] expColor;
  logic [7:0] expPixX;
  logic       expColl;
  logic       modelLive = 1'b0;
  integer     seed = 15;
  int         cycleCount = 0;

  tiaObjClock #(.ResetCycles(ResetCycles)) clkGen (.clk(clk), .rstN(rstN));

  tiaObjTop #(.LineWidth(LineWidth)) dut (
    .clk       (clk),
    .rstN      (rstN),
    .wrEn      (wrEn),
    .wrAddr    (wrAddr),
    .wrData    (wrData),
    .colorOut  (colorOut),
    .pixelX    (pixelX),
    .collision (collision)
  );

  // Object lit test from window, copy slots and stretched mask bits
  function automatic logic objLit(input int pix, input int pos, input int size,
                                  input logic [7:0] mask);
    int   idx;
    int   slot;
    int   bitSel;
    logic inWindow;
    logic slotOk;
    inWindow = (pix > pos) && (pix <= pos + tiaPkg::ObjWindow);
    idx = pix - pos - 1;
    slot = idx / 8;
    case (size)
      0: slotOk = (slot == 0);
      1: slotOk = (slot == 0) || (slot == 2);
      2: slotOk = (slot == 0) || (slot == 4);
      3: slotOk = (slot == 0) || (slot == 2) || (slot == 4);
      4: slotOk = (slot == 0) || (slot == 8);
      5: slotOk = (slot == 0) || (slot == 1);
      6: slotOk = (slot == 0) || (slot == 4) || (slot == 8);
      default: slotOk = (slot >= 0) && (slot <= 3);
    endcase
    if (size == 5) begin
      bitSel = (idx / 2) % 8;
    end else if (size == 7) begin
      bitSel = (idx / 4) % 8;
    end else begin
      bitSel = idx % 8;
    end
    return inWindow && slotOk && (idx >= 0) && mask[bitSel % 8];
  endfunction

  // Prediction for the pixel the DUT sees at this edge
  always @(posedge clk) begin : refModel
    logic playerLit;
    logic missileLit;
    modelLive = 1'b1;
    if (!rstN) begin
      mPix = '0;
      mLineStart = 1'b1;
      mNusiz = '0;
      mGrpNew = '0;
      mGrpOld = '0;
      mVdelay = 1'b0;
      mMisEn = 1'b0;
      mPlayerPos = '0;
      mMisPos = '0;
      mColup = '0;
      mColubk = '0;
      mClear = 1'b0;
      expColor = '0;
      expPixX = '0;
      expColl = 1'b0;
    end else begin
      playerLit = objLit(int'(mPix), int'(mPlayerPos), int'(mNusiz[2:0]),
                         mVdelay ? mGrpOld : mGrpNew);
      // Missile spans 2^size pixels starting one past its position
      missileLit = mMisEn && (mPix > mMisPos) &&
                   (int'(mPix) - int'(mMisPos) <= (1 << int'(mNusiz[7:6])));
      expPixX = mPix;
      expColor = (playerLit || missileLit) ? mColup : mColubk;
      if (mClear) begin
        expColl = 1'b0;
      end else if (playerLit && missileLit) begin
        expColl = 1'b1;
      end
      mClear = 1'b0;
      if (mLineStart) begin
        mGrpOld = mGrpNew;
      end
      if (wrEn) begin
        case (wrAddr)
          tiaPkg::AddrNusiz:  mNusiz = wrData;
          tiaPkg::AddrGrp:    mGrpNew = wrData;
          tiaPkg::AddrColup:  mColup = wrData;
          tiaPkg::AddrColubk: mColubk = wrData;
          tiaPkg::AddrResp:   mPlayerPos = mPix;
          tiaPkg::AddrResm:   mMisPos = mPix;
          tiaPkg::AddrCtrl: begin
            mVdelay = wrData[0];
            mMisEn = wrData[1];
          end
          tiaPkg::AddrCxclr:  mClear = 1'b1;
        endcase
      end
      mLineStart = (int'(mPix) == LineWidth - 1);
      mPix = mLineStart ? 8'd0 : mPix + 8'd1;
    end
  end

  task automatic checkColor(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h at pixel %h", name, got, exp, expPixX);
      $display("** FAIL **");
      $fatal(1, "byte mismatch");
    end
  endtask

  task automatic checkCollision(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h at pixel %h", name, got, exp, expPixX);
      $display("** FAIL **");
      $fatal(1, "flag mismatch");
    end
  endtask

  always @(negedge clk) begin
    if (modelLive) begin
      checkColor("colorOut", colorOut, expColor);
      checkColor("pixelX", pixelX, expPixX);
      checkCollision("collision", collision, expColl);
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > TimeoutCycles) begin
      $display("Run did not finish within %0d cycles", TimeoutCycles);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  // All stimulus tasks start and end on a falling edge
  task automatic writeReg(input logic [tiaPkg::AddrW-1:0] addr, input logic [7:0] data);
    wrEn = 1'b1;
    wrAddr = addr;
    wrData = data;
    @(negedge clk);
    wrEn = 1'b0;
  endtask

  task automatic writeAt(input logic [tiaPkg::AddrW-1:0] addr, input logic [7:0] data,
                         input logic [7:0] pix);
    while (mPix != pix) @(negedge clk);
    writeReg(addr, data);
  endtask

  task automatic waitLineStart();
    @(negedge clk);
    while (mPix != 8'd0) @(negedge clk);
  endtask

  // One line of setup at pixels 0..4, a strobe, then the rest of the line
  task automatic drawLine(input logic [7:0] nusizVal, input logic [7:0] grpVal,
                          input logic [7:0] ctrlVal,
                          input logic [tiaPkg::AddrW-1:0] strobeAddr,
                          input logic [7:0] pos);
    integer rnd;
    writeReg(tiaPkg::AddrNusiz, nusizVal);
    writeReg(tiaPkg::AddrGrp, grpVal);
    writeReg(tiaPkg::AddrCtrl, ctrlVal);
    rnd = $random(seed);
    writeReg(tiaPkg::AddrColup, rnd[7:0]);
    writeReg(tiaPkg::AddrColubk, rnd[15:8]);
    writeAt(strobeAddr, 8'h00, pos);
    waitLineStart();
  endtask

  function automatic logic [7:0] randPos();
    integer rnd;
    rnd = $random(seed);
    return 8'(8 + (rnd & 63));
  endfunction

  task automatic sweepSizes();
    for (int size = 0; size < 8; size++) begin
      drawLine(8'(size), 8'hff, 8'h00, tiaPkg::AddrResp, randPos());
    end
  endtask

  task automatic stretchedMasks();
    integer rnd;
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      drawLine((i % 2 == 0) ? 8'd5 : 8'd7, rnd[7:0], 8'h00, tiaPkg::AddrResp, randPos());
    end
  endtask

  task automatic positionEdges();
    drawLine(8'd6, 8'hff, 8'h00, tiaPkg::AddrResp, 8'd10);
    drawLine(8'd6, 8'hff, 8'h00, tiaPkg::AddrResp, 8'd87);
    drawLine(8'd6, 8'hff, 8'h00, tiaPkg::AddrResp, 8'd120);
    drawLine(8'd3, 8'hff, 8'h00, tiaPkg::AddrResp, 8'd158);
    drawLine(8'd7, 8'hff, 8'h00, tiaPkg::AddrResp, 8'd159);
  endtask

  task automatic verticalDelay();
    drawLine(8'd0, 8'h81, 8'h01, tiaPkg::AddrResp, 8'd20);
    // Held back until the next line start
    writeAt(tiaPkg::AddrGrp, 8'h3c, 8'd5);
    waitLineStart();
    waitLineStart();
    writeAt(tiaPkg::AddrCtrl, 8'h00, 8'd5);
    // Lands in the middle of the object
    writeAt(tiaPkg::AddrGrp, 8'he0, 8'd24);
    waitLineStart();
  endtask

  task automatic missileWidths();
    for (int ms = 0; ms < 4; ms++) begin
      drawLine(8'(ms << 6), 8'h00, 8'h02, tiaPkg::AddrResm, randPos());
    end
    drawLine(8'hc0, 8'h00, 8'h00, tiaPkg::AddrResm, randPos());
  endtask

  task automatic collisionLatch();
    drawLine(8'h40, 8'hff, 8'h02, tiaPkg::AddrResp, 8'd40);
    writeAt(tiaPkg::AddrResm, 8'h00, 8'd42);
    waitLineStart();
    // Clear lands on the first overlap pixel
    writeAt(tiaPkg::AddrCxclr, 8'h00, 8'd42);
    waitLineStart();
    writeAt(tiaPkg::AddrResp, 8'h00, 8'd5);
    writeAt(tiaPkg::AddrCxclr, 8'h00, 8'd30);
    waitLineStart();
    waitLineStart();
  endtask

  initial begin
    wrEn = 1'b0;
    wrAddr = '0;
    wrData = '0;
    @(posedge rstN);
    waitLineStart();
    sweepSizes();
    stretchedMasks();
    positionEdges();
    verticalDelay();
    missileWidths();
    collisionLatch();
    if (dut.render.renderChecker.assertFails == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("Renderer assertions failed %0d times", dut.render.renderChecker.assertFails);
      $display("** FAIL **");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// File: verilog.f
tiaPkg.sv
scanCounter.sv
objRegs.sv
objPixelOn.sv
objRender.sv
tiaObjTop.sv
objPixelOn_checker.sv
tiaObjClock.sv
tiaObjTb.sv

// File: Makefile
# Verilator build and run of the TIA object slice
LOG := sim.log

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tiaObjTb -o simv

run: build
	-./obj_dir/simv > $(LOG) 2>&1
	cat $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

lint:
	verilator --lint-only --timing -f verilog.f --top-module tiaObjTb

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
